// File: rtl/bus_pkg.sv
`default_nettype none

package bus_pkg;

    localparam int wb_adr_w = 32;
    localparam int wb_dat_w = 32;
    localparam int wb_sel_w = wb_dat_w / 8;

    localparam logic [wb_sel_w-1:0] wb_sel_all = '1; // every transfer here moves a full word

    // wishbone classic master to slave
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [wb_adr_w-1:0] adr;
        logic [wb_dat_w-1:0] dat;
        logic [wb_sel_w-1:0] sel;
    } wb_req_t;

    // slave to master without err or rty
    typedef struct packed {
        logic                ack;
        logic [wb_dat_w-1:0] dat;
    } wb_rsp_t;

    typedef enum logic [1:0] {
        arb_idle,
        arb_grant_cache,
        arb_grant_data
    } arb_state_t;

endpackage

`default_nettype wire

// File: rtl/frontend_pkg.sv
`default_nettype none

package frontend_pkg;

    localparam int xlen         = 32;
    localparam int if_width     = 2;                          // instructions per bundle
    localparam int bundle_off_w = $clog2(if_width * xlen / 8); // byte offset inside a bundle

    localparam logic [xlen-1:0] reset_vector = 32'h1eceb000;

    localparam int queue_depth   = 8;
    localparam int queue_count_w = $clog2(queue_depth + 1);
    localparam int queue_ptr_w   = $clog2(queue_depth);

    localparam int line_words = 4;
    localparam int num_lines  = 16;
    localparam int word_off_w = $clog2(line_words);
    localparam int offset_w   = word_off_w + 2;            // byte offset inside a line
    localparam int index_w    = $clog2(num_lines);
    localparam int tag_w      = xlen - offset_w - index_w;

    typedef struct packed {
        logic [xlen-1:0]          pc;
        logic [if_width*xlen-1:0] instr; // word at pc sits in the low bits
    } fetch_bundle_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] target;
    } redirect_t;

    typedef enum logic [1:0] {
        ic_idle,
        ic_lookup,
        ic_refill
    } icache_state_t;

endpackage

`default_nettype wire

// File: rtl/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage
    import frontend_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  redirect_t                redirect,
    output logic                     lookup_valid,
    output logic [xlen-1:0]          lookup_addr,
    input  logic                     cache_busy,
    input  logic                     rsp_valid,
    input  fetch_bundle_t            rsp_bundle,
    input  logic [queue_count_w-1:0] queue_count,
    output logic                     enq_valid,
    output fetch_bundle_t            enq_bundle
);

    logic [xlen-1:0] pc;
    logic            pending;    // one lookup is outstanding at the cache
    logic            stale;      // the outstanding lookup belongs to a flushed stream
    logic            queue_near_full;
    logic            rsp_live;

    // one free entry is kept for the bundle that may still be in flight
    assign queue_near_full = queue_count >= queue_count_w'(queue_depth - 1);

    assign lookup_valid = !pending && !cache_busy && !queue_near_full && !redirect.valid;
    assign lookup_addr  = pc;

    assign rsp_live   = rsp_valid && !stale && !redirect.valid;
    assign enq_valid  = rsp_live;
    assign enq_bundle = rsp_bundle;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= reset_vector;
            pending <= 1'b0;
            stale   <= 1'b0;
        end else begin
            if (redirect.valid) begin
                pc <= {redirect.target[xlen-1:bundle_off_w], bundle_off_w'(0)};
            end else if (rsp_live) begin
                pc <= pc + xlen'(if_width * xlen / 8);
            end

            if (lookup_valid) begin
                pending <= 1'b1;
            end else if (rsp_valid) begin
                pending <= 1'b0;
            end

            // a response in the redirect cycle is already dropped above
            if (rsp_valid) begin
                stale <= 1'b0;
            end else if (redirect.valid && pending) begin
                stale <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache
    import frontend_pkg::*;
    import bus_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            lookup_valid,
    input  logic [xlen-1:0] lookup_addr,
    output logic            rsp_valid,
    output fetch_bundle_t   rsp_bundle,
    output logic            busy,
    output wb_req_t         wb_req,
    input  wb_rsp_t         wb_rsp
);

    logic [tag_w-1:0]      tag_mem  [num_lines];
    logic [xlen-1:0]       data_mem [num_lines][line_words];
    logic [num_lines-1:0]  line_valid;

    icache_state_t         state;
    logic [xlen-1:0]       req_addr;
    logic [word_off_w-1:0] beat;      // word of the line being refilled
    logic [index_w-1:0]    req_index;
    logic [tag_w-1:0]      req_tag;
    logic [word_off_w-1:0] pair_base;
    logic                  hit;
    logic                  last_beat;

    assign req_index = req_addr[offset_w +: index_w];
    assign req_tag   = req_addr[xlen-1 -: tag_w];
    assign pair_base = req_addr[2 +: word_off_w] & word_off_w'(~(if_width - 1));
    assign hit       = line_valid[req_index] && (tag_mem[req_index] == req_tag);
    assign last_beat = beat == word_off_w'(line_words - 1);

    assign busy      = state == ic_refill;
    assign rsp_valid = (state == ic_lookup) && hit;

    always_comb begin
        rsp_bundle.pc = req_addr;
        for (int i = 0; i < if_width; i++) begin
            rsp_bundle.instr[xlen*i +: xlen] = data_mem[req_index][pair_base + word_off_w'(i)];
        end
    end

    // cyc stays up across all beats of the line
    always_comb begin
        wb_req     = '0;
        wb_req.cyc = busy;
        wb_req.stb = busy;
        wb_req.we  = 1'b0;
        wb_req.adr = {req_addr[xlen-1:offset_w], beat, 2'b00};
        wb_req.sel = wb_sel_all;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ic_idle;
            beat       <= '0;
            line_valid <= '0;
        end else begin
            case (state)
                ic_idle: begin
                    if (lookup_valid) begin
                        state <= ic_lookup;
                    end
                end
                ic_lookup: begin
                    state <= hit ? ic_idle : ic_refill;
                end
                ic_refill: begin
                    if (wb_rsp.ack) begin
                        beat <= beat + 1'b1; // wraps back to zero after the last word
                        if (last_beat) begin
                            line_valid[req_index] <= 1'b1;
                            state                 <= ic_lookup; // replay hits next cycle
                        end
                    end
                end
                default: begin
                    state <= ic_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == ic_idle) && lookup_valid) begin
            req_addr <= lookup_addr;
        end
        if (busy && wb_rsp.ack) begin
            data_mem[req_index][beat] <= wb_rsp.dat;
            if (last_beat) begin
                tag_mem[req_index] <= req_tag;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/instr_queue.sv
`timescale 1ns/1ps
`default_nettype none

module instr_queue
    import frontend_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     flush,
    input  logic                     enq_valid,
    input  fetch_bundle_t            enq_bundle,
    output logic [queue_count_w-1:0] count,
    output logic                     out_valid,
    output fetch_bundle_t            out_bundle,
    input  logic                     out_ready
);

    fetch_bundle_t          entries [queue_depth];
    logic [queue_ptr_w-1:0] rd_ptr;
    logic [queue_ptr_w-1:0] wr_ptr;
    logic                   full;
    logic                   do_enq;
    logic                   do_deq;

    assign full       = count == queue_count_w'(queue_depth);
    assign out_valid  = count != '0;
    assign out_bundle = entries[rd_ptr];

    assign do_enq = enq_valid && !full;
    assign do_deq = out_valid && out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            rd_ptr <= '0; // flush wins over an enqueue in the same cycle
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_deq) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + queue_count_w'(do_enq) - queue_count_w'(do_deq);
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            entries[wr_ptr] <= enq_bundle;
        end
    end

endmodule

`default_nettype wire

// File: rtl/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter
    import bus_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  wb_req_t cache_req,
    output wb_rsp_t cache_rsp,
    input  wb_req_t data_req,
    output wb_rsp_t data_rsp,
    output wb_req_t mem_req,
    input  wb_rsp_t mem_rsp
);

    arb_state_t state;
    arb_state_t state_next;
    logic       last_data; // data port held the bus most recently

    always_comb begin
        state_next = state;
        case (state)
            arb_idle: begin
                if (cache_req.cyc && data_req.cyc) begin
                    state_next = last_data ? arb_grant_cache : arb_grant_data;
                end else if (cache_req.cyc) begin
                    state_next = arb_grant_cache;
                end else if (data_req.cyc) begin
                    state_next = arb_grant_data;
                end
            end
            arb_grant_cache: begin
                if (!cache_req.cyc) begin
                    state_next = arb_idle;
                end
            end
            arb_grant_data: begin
                if (!data_req.cyc) begin
                    state_next = arb_idle;
                end
            end
            default: begin
                state_next = arb_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= arb_idle;
            last_data <= 1'b0;
        end else begin
            state <= state_next;
            if (state == arb_idle && state_next != arb_idle) begin
                last_data <= state_next == arb_grant_data;
            end
        end
    end

    // only the granted master sees the bus and its ack
    always_comb begin
        mem_req       = '0;
        cache_rsp.dat = mem_rsp.dat;
        cache_rsp.ack = 1'b0;
        data_rsp.dat  = mem_rsp.dat;
        data_rsp.ack  = 1'b0;
        case (state)
            arb_grant_cache: begin
                mem_req       = cache_req;
                cache_rsp.ack = mem_rsp.ack;
            end
            arb_grant_data: begin
                mem_req      = data_req;
                data_rsp.ack = mem_rsp.ack;
            end
            default: begin
                mem_req = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/frontend_top.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_top
    import frontend_pkg::*;
    import bus_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  redirect_t     redirect,
    output logic          out_valid,
    output fetch_bundle_t out_bundle,
    input  logic          out_ready,
    input  wb_req_t       data_req,
    output wb_rsp_t       data_rsp,
    output wb_req_t       mem_req,
    input  wb_rsp_t       mem_rsp
);

    logic                     lookup_valid;
    logic [xlen-1:0]          lookup_addr;
    logic                     cache_busy;
    logic                     rsp_valid;
    fetch_bundle_t            rsp_bundle;
    logic                     enq_valid;
    fetch_bundle_t            enq_bundle;
    logic [queue_count_w-1:0] queue_count;
    wb_req_t                  cache_req;
    wb_rsp_t                  cache_rsp;

    fetch_stage fetch_stage_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .redirect     (redirect),
        .lookup_valid (lookup_valid),
        .lookup_addr  (lookup_addr),
        .cache_busy   (cache_busy),
        .rsp_valid    (rsp_valid),
        .rsp_bundle   (rsp_bundle),
        .queue_count  (queue_count),
        .enq_valid    (enq_valid),
        .enq_bundle   (enq_bundle)
    );

    icache icache_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup_valid (lookup_valid),
        .lookup_addr  (lookup_addr),
        .rsp_valid    (rsp_valid),
        .rsp_bundle   (rsp_bundle),
        .busy         (cache_busy),
        .wb_req       (cache_req),
        .wb_rsp       (cache_rsp)
    );

    // a resolved branch empties the queue in the same cycle
    instr_queue instr_queue_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (redirect.valid),
        .enq_valid  (enq_valid),
        .enq_bundle (enq_bundle),
        .count      (queue_count),
        .out_valid  (out_valid),
        .out_bundle (out_bundle),
        .out_ready  (out_ready)
    );

    bus_arbiter bus_arbiter_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cache_req (cache_req),
        .cache_rsp (cache_rsp),
        .data_req  (data_req),
        .data_rsp  (data_rsp),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

endmodule

`default_nettype wire

// File: testbench/tb_wb_memory.sv
`timescale 1ns/1ps
`default_nettype none

module tb_wb_memory
    import bus_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  wb_req_t req,
    output wb_rsp_t rsp
);

    logic [wb_dat_w-1:0] written [logic [wb_adr_w-1:0]]; // words stored by write cycles
    int unsigned         delay;                           // wait cycles left before the next ack

    function automatic logic [wb_dat_w-1:0] read_word(input logic [wb_adr_w-1:0] adr);
        if (written.exists(adr)) begin
            return written[adr];
        end
        return (adr * 32'h9e3779b1) ^ adr; // fill pattern for words never written
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp   <= '0;
            delay <= 0;
        end else begin
            rsp.ack <= 1'b0;
            // the ack cycle itself is skipped so one request is never acked twice
            if (req.cyc && req.stb && !rsp.ack) begin
                if (delay == 0) begin
                    rsp.ack <= 1'b1;
                    if (req.we) begin
                        written[req.adr] = req.dat;
                    end else begin
                        rsp.dat <= read_word(req.adr);
                    end
                    delay <= $urandom_range(3, 0);
                end else begin
                    delay <= delay - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_frontend_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_frontend_top
    import frontend_pkg::*;
    import bus_pkg::*;
();

    logic            clk;
    logic            rst_n;
    redirect_t       redirect;
    logic            out_valid;
    fetch_bundle_t   out_bundle;
    logic            out_ready;
    wb_req_t         data_req;
    wb_rsp_t         data_rsp;
    wb_req_t         mem_req;
    wb_rsp_t         mem_rsp;

    logic [xlen-1:0] shadow [logic [xlen-1:0]]; // words written through the data port
    logic [xlen-1:0] exp_pc;
    int              bundle_count;
    int              check_count;
    int              error_count;
    int              reuse_reads;
    logic            reuse_watch;
    logic            ready_hold;
    logic            ready_hold_seen;

    frontend_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .redirect   (redirect),
        .out_valid  (out_valid),
        .out_bundle (out_bundle),
        .out_ready  (out_ready),
        .data_req   (data_req),
        .data_rsp   (data_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp)
    );

    tb_wb_memory memory (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (mem_req),
        .rsp   (mem_rsp)
    );

    function automatic logic [xlen-1:0] expected_word(input logic [xlen-1:0] adr);
        if (shadow.exists(adr)) begin
            return shadow[adr];
        end
        return (adr * 32'h9e3779b1) ^ adr;
    endfunction

    function automatic fetch_bundle_t expected_bundle(input logic [xlen-1:0] pc);
        fetch_bundle_t b;
        b.pc = pc;
        for (int i = 0; i < if_width; i++) begin
            b.instr[xlen*i +: xlen] = expected_word(pc + xlen'(4 * i)); // word at pc goes low
        end
        return b;
    endfunction

    task automatic compare_bundle(input fetch_bundle_t got, input fetch_bundle_t exp);
        check_count++;
        if (got.pc !== exp.pc) begin
            $display("error: out_bundle.pc got %h expected %h", got.pc, exp.pc);
            error_count++;
        end else if (got.instr !== exp.instr) begin
            $display("error: out_bundle.instr at pc %h got %h expected %h",
                     got.pc, got.instr, exp.instr);
            error_count++;
        end
    endtask

    task automatic compare_word(input string name, input logic [xlen-1:0] got,
                                input logic [xlen-1:0] exp);
        check_count++;
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic wait_bundles(input int n, input int limit, input string what);
        int target;
        int cycles;
        target = bundle_count + n;
        cycles = 0;
        while (bundle_count < target && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (bundle_count < target) begin
            $display("timeout: %s saw only %0d of %0d bundles within %0d cycles",
                     what, n - (target - bundle_count), n, limit);
            error_count++;
        end
    endtask

    task automatic issue_redirect(input logic [xlen-1:0] target);
        @(posedge clk);
        #2 ready_hold = 1'b1; // no dequeue in the flush cycle
        @(posedge clk);
        #2;
        redirect.valid  = 1'b1;
        redirect.target = target;
        @(posedge clk);
        #2;
        redirect   = '0;
        ready_hold = 1'b0;
    endtask

    task automatic data_access(input logic we, input logic [xlen-1:0] adr,
                               input logic [xlen-1:0] wdat, output logic [xlen-1:0] rdat);
        int   cycles;
        logic acked;
        acked = 1'b0;
        cycles = 0;
        rdat = '0;
        @(posedge clk);
        #2;
        data_req.cyc = 1'b1;
        data_req.stb = 1'b1;
        data_req.we  = we;
        data_req.adr = adr;
        data_req.dat = wdat;
        data_req.sel = wb_sel_all;
        while (!acked && cycles < 200) begin
            @(negedge clk);
            if (data_rsp.ack) begin
                acked = 1'b1;
                rdat  = data_rsp.dat;
            end
            cycles++;
        end
        @(posedge clk);
        #2 data_req = '0;
        if (!acked) begin
            $display("timeout: data port access to %h was never acknowledged", adr);
            error_count++;
        end
    endtask

    task automatic data_write(input logic [xlen-1:0] adr, input logic [xlen-1:0] wdat);
        logic [xlen-1:0] unused;
        data_access(1'b1, adr, wdat, unused);
        shadow[adr] = wdat;
    endtask

    task automatic data_read(input logic [xlen-1:0] adr);
        logic [xlen-1:0] rdat;
        data_access(1'b0, adr, '0, rdat);
        compare_word("data_rsp.dat", rdat, expected_word(adr));
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        ready_hold_seen = ready_hold; // hold request as it stood at the edge
        #2 out_ready = !ready_hold_seen && ($urandom_range(3, 0) != 0); // ready three times in four
    end

    // every bundle that leaves the queue is checked against the expected pc stream
    always @(negedge clk) begin
        if (rst_n) begin
            if (redirect.valid) begin
                exp_pc = {redirect.target[xlen-1:3], 3'b000};
            end else if (out_valid && out_ready) begin
                compare_bundle(out_bundle, expected_bundle(exp_pc));
                exp_pc = exp_pc + xlen'(8);
                bundle_count++;
            end
            if (reuse_watch && mem_req.cyc && mem_req.stb && !mem_req.we &&
                mem_req.adr >= reset_vector && mem_req.adr < reset_vector + xlen'(64)) begin
                reuse_reads++;
            end
        end
    end

    initial begin
        int errs_before;
        int cycles;
        int stall_drops;
        void'($urandom(32'he85ad48b));
        rst_n        = 1'b0;
        redirect     = '0;
        out_ready    = 1'b0;
        data_req     = '0;
        ready_hold   = 1'b0;
        reuse_watch  = 1'b0;
        reuse_reads  = 0;
        exp_pc       = reset_vector;
        bundle_count = 0;
        check_count  = 0;
        error_count  = 0;
        repeat (4) @(posedge clk);
        #2 rst_n = 1'b1;

        errs_before = error_count;
        wait_bundles(40, 4000, "sequential fetch");
        report_test("test 1 sequential fetch", errs_before);

        errs_before = error_count;
        @(posedge clk);
        #2 ready_hold = 1'b1;
        repeat (2) @(posedge clk);
        cycles = 0;
        @(negedge clk);
        while (!out_valid && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (!out_valid) begin
            $display("timeout: out_valid never rose before the stall check");
            error_count++;
        end
        stall_drops = 0;
        repeat (30) begin
            @(negedge clk);
            if (!out_valid) begin
                stall_drops++;
            end
        end
        if (stall_drops != 0) begin
            $display("out_valid dropped in %0d cycles while out_ready was held low",
                     stall_drops);
            error_count++;
        end
        ready_hold = 1'b0;
        wait_bundles(10, 2000, "release after stall");
        report_test("test 2 back-pressure", errs_before);

        errs_before = error_count;
        issue_redirect(32'h2f001234);
        wait_bundles(6, 2000, "redirect to far target");
        report_test("test 3 redirect", errs_before);

        errs_before = error_count;
        issue_redirect(reset_vector); // brings the first lines back into the cache
        wait_bundles(8, 2000, "cache warm-up");
        issue_redirect(reset_vector);
        reuse_watch = 1'b1;
        wait_bundles(8, 2000, "cache reuse");
        reuse_watch = 1'b0;
        if (reuse_reads != 0) begin
            $display("cached lines were read from memory again in %0d bus cycles",
                     reuse_reads);
            error_count++;
        end
        report_test("test 4 cache reuse", errs_before);

        errs_before = error_count;
        issue_redirect(32'h3a5c0000);
        fork
            begin
                data_read(32'h80000200);
                for (int i = 0; i < 6; i++) begin
                    data_write(32'h80000000 + xlen'(4 * (i % 3)), $urandom);
                    data_read(32'h80000000 + xlen'(4 * (i % 3)));
                end
            end
            wait_bundles(24, 4000, "fetch during data traffic");
        join
        report_test("test 5 shared bus", errs_before);

        $display("bundles %0d checks %0d errors %0d", bundle_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: frontend_top.f
rtl/bus_pkg.sv
rtl/frontend_pkg.sv
rtl/fetch_stage.sv
rtl/icache.sv
rtl/instr_queue.sv
rtl/bus_arbiter.sv
rtl/frontend_top.sv
testbench/tb_wb_memory.sv
testbench/tb_frontend_top.sv

// File: run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_frontend_top \
    -f frontend_top.f -Mdir obj_dir -o sim_frontend > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/sim_frontend > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi

if grep -qx "Simulation PASSED" sim.log; then
    exit 0
fi
exit 1
